// File: Bender.yml
package:
  name: sdspi

sources:
  - hw/sdspi_pkg.sv
  - hw/sdspi_fifo.sv
  - hw/sdspi_clkgen.sv
  - hw/sdspi_engine.sv
  - hw/sdspi_regs.sv
  - hw/sdspi_top.sv
  - target: test
    files:
      - verif/sdspi_tb.sv

// File: all.f
hw/sdspi_pkg.sv
hw/sdspi_fifo.sv
hw/sdspi_clkgen.sv
hw/sdspi_engine.sv
hw/sdspi_regs.sv
hw/sdspi_top.sv
verif/sdspi_tb.sv

// File: hw/sdspi_clkgen.sv
// SPI baud scaler
`timescale 1ns/10ps
`default_nettype none

module sdspi_clkgen (
    input wire logic i_clk,
    input wire logic i_nrst,
    input wire logic [sdspi_pkg::scaler_w-1:0] i_scaler,
    input wire logic i_restart,
    output logic o_level,
    output logic o_rise,
    output logic o_fall
);

    logic [sdspi_pkg::scaler_w-1:0] cnt_q;
    logic tick;

    // a zero scaler holds the level where it is
    assign tick = (|i_scaler) && (cnt_q == i_scaler - 1'b1) && !i_restart;
    assign o_rise = tick && !o_level;                       // level about to go high
    assign o_fall = tick && o_level;                        // level about to go low

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            cnt_q <= '0;
            o_level <= 1'b1;
        end else if (i_restart) begin
            cnt_q <= '0;                                    // new scaler value
        end else if (|i_scaler) begin
            if (tick) begin
                cnt_q <= '0;
                o_level <= !o_level;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    a_edge_excl: assert property (@(posedge i_clk) disable iff (!i_nrst)
        !(o_rise && o_fall));

endmodule

`default_nettype wire

// File: hw/sdspi_engine.sv
// SPI transfer engine with CRC7
`timescale 1ns/10ps
`default_nettype none

module sdspi_engine (
    input wire logic i_clk,
    input wire logic i_nrst,
    input wire logic i_rise,
    input wire logic i_fall,
    input wire logic i_level,
    input wire logic i_ctrl_we,
    input wire sdspi_pkg::spi_ctrl_t i_ctrl,
    input wire logic [7:0] i_tx_rdata,
    input wire logic [sdspi_pkg::fifo_log2_depth:0] i_tx_count,
    output logic o_tx_re,
    output logic o_rx_we,
    output logic [7:0] o_rx_wdata,
    input wire logic i_miso,
    output logic o_cs,
    output logic o_sclk,
    output logic o_mosi,
    output sdspi_pkg::spi_status_t o_status
);

    sdspi_pkg::state_t state_q;
    logic cs_q;                                             // chip select, active high inside
    logic gen_crc_q;
    logic rx_ena_q;
    logic [sdspi_pkg::byte_cnt_w-1:0] byte_cnt_q;
    logic [2:0] bit_cnt_q;
    logic [7:0] tx_val_q;
    logic [7:0] shift_q;
    logic [6:0] crc7_q;
    logic [6:0] crc_next;
    logic crc_inv;
    logic [7:0] shift_next;
    logic [7:0] next_tx;
    logic last_rise;

    // CRC7, x^7 + x^3 + 1, fed with the bit on MOSI
    assign crc_inv = crc7_q[6] ^ shift_q[7];
    assign crc_next = {crc7_q[5:3], crc7_q[2] ^ crc_inv, crc7_q[1:0], crc_inv};

    assign shift_next = {shift_q[6:0], rx_ena_q ? i_miso : 1'b1};
    assign next_tx = ((i_tx_count == '0) || rx_ena_q) ? 8'hFF : i_tx_rdata;
    assign last_rise = i_rise && (bit_cnt_q == 3'd0);       // eighth rise of a byte

    always_comb begin
        o_tx_re = 1'b0;
        if (state_q == sdspi_pkg::idle && (|byte_cnt_q)) begin
            o_tx_re = !rx_ena_q;
        end else if (state_q == sdspi_pkg::send_data && last_rise && (|byte_cnt_q)) begin
            o_tx_re = 1'b1;
        end
    end

    assign o_rx_we = (state_q == sdspi_pkg::recv_data) && last_rise;
    assign o_rx_wdata = shift_next;                         // includes the last sampled bit

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state_q <= sdspi_pkg::idle;
            cs_q <= 1'b0;
            gen_crc_q <= 1'b0;
            rx_ena_q <= 1'b0;
            byte_cnt_q <= '0;
            bit_cnt_q <= '0;
            tx_val_q <= 8'hFF;
            shift_q <= 8'hFF;
            crc7_q <= '0;
        end else begin
            // transmit shifts on fall, receive samples on rise
            if (cs_q && ((i_fall && !rx_ena_q) || (i_rise && rx_ena_q))) begin
                shift_q <= shift_next;
            end
            if (cs_q && i_fall) begin
                if (|bit_cnt_q) begin
                    bit_cnt_q <= bit_cnt_q - 1'b1;
                end else begin
                    cs_q <= 1'b0;                           // byte done, may be re-taken below
                end
            end
            if (cs_q && i_rise) begin
                crc7_q <= crc_next;
            end

            case (state_q)
                sdspi_pkg::idle: begin
                    if (|byte_cnt_q) begin
                        tx_val_q <= next_tx;
                        byte_cnt_q <= byte_cnt_q - 1'b1;
                        crc7_q <= '0;                       // new command
                        state_q <= sdspi_pkg::wait_edge;
                    end
                end
                sdspi_pkg::wait_edge: begin
                    if (i_fall) begin
                        cs_q <= 1'b1;
                        bit_cnt_q <= 3'd7;
                        shift_q <= rx_ena_q ? 8'h00 : tx_val_q;
                        state_q <= rx_ena_q ? sdspi_pkg::recv_data : sdspi_pkg::send_data;
                    end
                end
                sdspi_pkg::send_data: begin
                    if (last_rise) begin
                        if (|byte_cnt_q) begin
                            tx_val_q <= next_tx;
                            byte_cnt_q <= byte_cnt_q - 1'b1;
                            state_q <= sdspi_pkg::wait_edge;
                        end else if (gen_crc_q) begin
                            tx_val_q <= {crc_next, sdspi_pkg::crc_tail_bit};
                            gen_crc_q <= 1'b0;              // one CRC byte only
                            state_q <= sdspi_pkg::wait_edge;
                        end else begin
                            state_q <= sdspi_pkg::ending;
                        end
                    end
                end
                sdspi_pkg::recv_data: begin
                    if (last_rise) begin
                        if (|byte_cnt_q) begin
                            byte_cnt_q <= byte_cnt_q - 1'b1;
                            state_q <= sdspi_pkg::wait_edge;
                        end else begin
                            state_q <= sdspi_pkg::ending;
                        end
                    end
                end
                sdspi_pkg::ending: begin
                    if (!cs_q) begin
                        state_q <= sdspi_pkg::idle;         // wait for CS release
                    end
                end
                default: state_q <= sdspi_pkg::idle;
            endcase

            if (i_ctrl_we) begin
                gen_crc_q <= i_ctrl.generate_crc;
                rx_ena_q <= i_ctrl.rx_ena;
                byte_cnt_q <= i_ctrl.byte_cnt;
            end
        end
    end

    assign o_cs = !cs_q;
    assign o_sclk = i_level && cs_q;
    assign o_mosi = rx_ena_q || shift_q[7];                 // idle high while receiving

    assign o_status = '{
        state: state_q,
        generate_crc: gen_crc_q,
        rx_ena: rx_ena_q,
        byte_cnt: byte_cnt_q
    };

    a_sclk_cs: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_cs |-> !o_sclk);

    a_state_legal: assert property (@(posedge i_clk) disable iff (!i_nrst)
        state_q inside {sdspi_pkg::idle, sdspi_pkg::wait_edge, sdspi_pkg::send_data,
                        sdspi_pkg::recv_data, sdspi_pkg::ending});

endmodule

`default_nettype wire

// File: hw/sdspi_fifo.sv
// Byte FIFO with fallthrough read
`timescale 1ns/10ps
`default_nettype none

module sdspi_fifo #(
    parameter int log2_depth = sdspi_pkg::fifo_log2_depth
) (
    input wire logic i_clk,
    input wire logic i_nrst,
    input wire logic i_we,
    input wire logic [7:0] i_wdata,
    input wire logic i_re,
    output logic [7:0] o_rdata,
    output logic [log2_depth:0] o_count
);

    logic [7:0] mem [2**log2_depth];
    logic [log2_depth-1:0] wr_ptr_q;
    logic [log2_depth-1:0] rd_ptr_q;
    logic full;
    logic do_wr;
    logic do_rd;

    assign full = (o_count == (log2_depth + 1)'(1 << log2_depth));
    assign do_wr = i_we && !full;                           // drop writes when full
    assign do_rd = i_re && (o_count != '0);                 // drop reads when empty

    always_ff @(posedge i_clk) begin
        if (do_wr) begin
            mem[wr_ptr_q] <= i_wdata;
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            o_count <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_rd) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10: o_count <= o_count + 1'b1;
                2'b01: o_count <= o_count - 1'b1;
                default: o_count <= o_count;                // idle or push+pop
            endcase
        end
    end

    assign o_rdata = mem[rd_ptr_q];                         // head byte always visible

    a_count_bound: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_count <= (log2_depth + 1)'(1 << log2_depth));

endmodule

`default_nettype wire

// File: hw/sdspi_pkg.sv
// SD SPI host shared definitions
`default_nettype none

package sdspi_pkg;

    localparam int fifo_log2_depth = 4;                     // 16 bytes per FIFO
    localparam int fifo_depth = 1 << fifo_log2_depth;

    // register word offsets, decoded on addr[11:2]
    localparam logic [11:0] addr_scaler = 12'h000;
    localparam logic [11:0] addr_ctrl = 12'h044;
    localparam logic [11:0] addr_txdata = 12'h048;
    localparam logic [11:0] addr_rxdata = 12'h04C;

    localparam int byte_cnt_w = 16;
    localparam int scaler_w = 31;

    localparam logic crc_tail_bit = 1'b1;                   // stop bit after CRC7

    // encoding kept compatible with older status readers
    typedef enum logic [2:0] {
        idle = 3'd0,
        wait_edge = 3'd1,
        send_data = 3'd2,
        recv_data = 3'd3,
        ending = 3'd5
    } state_t;

    typedef struct packed {
        logic valid;
        logic write;
        logic [31:0] addr;
        logic [31:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic valid;
        logic [31:0] rdata;
    } bus_resp_t;

    typedef struct packed {
        logic generate_crc;
        logic rx_ena;
        logic [byte_cnt_w-1:0] byte_cnt;
    } spi_ctrl_t;

    typedef struct packed {
        state_t state;
        logic generate_crc;
        logic rx_ena;
        logic [byte_cnt_w-1:0] byte_cnt;                    // bytes still to go
    } spi_status_t;

endpackage

`default_nettype wire

// File: hw/sdspi_regs.sv
// SD SPI register block
`timescale 1ns/10ps
`default_nettype none

module sdspi_regs (
    input wire logic i_clk,
    input wire logic i_nrst,
    input wire sdspi_pkg::bus_req_t i_req,
    output sdspi_pkg::bus_resp_t o_resp,
    output logic [sdspi_pkg::scaler_w-1:0] o_scaler,
    output logic o_scaler_we,
    output logic o_ctrl_we,
    output sdspi_pkg::spi_ctrl_t o_ctrl,
    output logic o_tx_we,
    output logic [7:0] o_tx_wdata,
    input wire logic [sdspi_pkg::fifo_log2_depth:0] i_tx_count,
    output logic o_rx_re,
    input wire logic [7:0] i_rx_rdata,
    input wire logic [sdspi_pkg::fifo_log2_depth:0] i_rx_count,
    input wire sdspi_pkg::spi_status_t i_status,
    input wire logic i_miso
);

    logic [9:0] idx;
    logic wr;
    logic rd;
    logic tx_full;
    logic [31:0] rdata;
    logic resp_valid_q;
    logic [31:0] resp_rdata_q;

    assign idx = i_req.addr[11:2];
    assign wr = i_req.valid && i_req.write;
    assign rd = i_req.valid && !i_req.write;
    assign tx_full = (i_tx_count ==
        (sdspi_pkg::fifo_log2_depth + 1)'(sdspi_pkg::fifo_depth));

    // strobes fire in the request cycle
    assign o_scaler_we = wr && (idx == sdspi_pkg::addr_scaler[11:2]);
    assign o_ctrl_we = wr && (idx == sdspi_pkg::addr_ctrl[11:2]);
    assign o_tx_we = wr && (idx == sdspi_pkg::addr_txdata[11:2]);
    assign o_rx_re = rd && (idx == sdspi_pkg::addr_rxdata[11:2]);
    assign o_tx_wdata = i_req.wdata[7:0];

    assign o_ctrl = '{
        generate_crc: i_req.wdata[7],
        rx_ena: i_req.wdata[8],
        byte_cnt: i_req.wdata[31:16]
    };

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            o_scaler <= '0;
        end else if (o_scaler_we) begin
            o_scaler <= i_req.wdata[sdspi_pkg::scaler_w-1:0];
        end
    end

    always_comb begin
        rdata = '0;
        case (idx)
            sdspi_pkg::addr_scaler[11:2]: rdata = {1'b0, o_scaler};
            sdspi_pkg::addr_ctrl[11:2]: begin
                rdata[2] = i_miso;                          // live card output
                rdata[6:4] = i_status.state;
                rdata[7] = i_status.generate_crc;
                rdata[8] = i_status.rx_ena;
                rdata[31:16] = i_status.byte_cnt;
            end
            sdspi_pkg::addr_txdata[11:2]: rdata[31] = tx_full;
            sdspi_pkg::addr_rxdata[11:2]: begin
                rdata[7:0] = i_rx_rdata;                    // head byte, popped by this read
                rdata[31] = (i_rx_count == '0);
            end
            default: rdata = '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            resp_valid_q <= 1'b0;
        end else begin
            resp_valid_q <= i_req.valid;
        end
    end

    always_ff @(posedge i_clk) begin
        resp_rdata_q <= rdata;
    end

    assign o_resp = '{valid: resp_valid_q, rdata: resp_rdata_q};

endmodule

`default_nettype wire

// File: hw/sdspi_top.sv
// SD card SPI host top level
`timescale 1ns/10ps
`default_nettype none

module sdspi_top (
    input wire logic i_clk,
    input wire logic i_nrst,
    input wire sdspi_pkg::bus_req_t i_req,
    output sdspi_pkg::bus_resp_t o_resp,
    output logic o_cs,
    output logic o_sclk,
    output logic o_mosi,
    input wire logic i_miso
);

    logic [sdspi_pkg::scaler_w-1:0] scaler;
    logic scaler_we;
    logic ctrl_we;
    sdspi_pkg::spi_ctrl_t ctrl;
    sdspi_pkg::spi_status_t status;
    logic level;
    logic rise;
    logic fall;
    logic tx_we;
    logic [7:0] tx_wdata;
    logic tx_re;
    logic [7:0] tx_rdata;
    logic [sdspi_pkg::fifo_log2_depth:0] tx_count;
    logic rx_we;
    logic [7:0] rx_wdata;
    logic rx_re;
    logic [7:0] rx_rdata;
    logic [sdspi_pkg::fifo_log2_depth:0] rx_count;

    sdspi_regs u_regs (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_req(i_req), .o_resp(o_resp),
        .o_scaler(scaler), .o_scaler_we(scaler_we),
        .o_ctrl_we(ctrl_we), .o_ctrl(ctrl),
        .o_tx_we(tx_we), .o_tx_wdata(tx_wdata), .i_tx_count(tx_count),
        .o_rx_re(rx_re), .i_rx_rdata(rx_rdata), .i_rx_count(rx_count),
        .i_status(status), .i_miso(i_miso)
    );

    sdspi_clkgen u_clkgen (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_scaler(scaler), .i_restart(scaler_we),
        .o_level(level), .o_rise(rise), .o_fall(fall)
    );

    sdspi_engine u_engine (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_rise(rise), .i_fall(fall), .i_level(level),
        .i_ctrl_we(ctrl_we), .i_ctrl(ctrl),
        .i_tx_rdata(tx_rdata), .i_tx_count(tx_count), .o_tx_re(tx_re),
        .o_rx_we(rx_we), .o_rx_wdata(rx_wdata), .i_miso(i_miso),
        .o_cs(o_cs), .o_sclk(o_sclk), .o_mosi(o_mosi), .o_status(status)
    );

    sdspi_fifo #(.log2_depth(sdspi_pkg::fifo_log2_depth)) u_txfifo (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_we(tx_we), .i_wdata(tx_wdata),
        .i_re(tx_re), .o_rdata(tx_rdata), .o_count(tx_count)
    );

    sdspi_fifo #(.log2_depth(sdspi_pkg::fifo_log2_depth)) u_rxfifo (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_we(rx_we), .i_wdata(rx_wdata),
        .i_re(rx_re), .o_rdata(rx_rdata), .o_count(rx_count)
    );

endmodule

`default_nettype wire

// File: verif/sdspi_tb.sv
// SD SPI host testbench
`timescale 1ns/10ps
`default_nettype none

module sdspi_tb;

    localparam int n_cases = 8;
    localparam int max_bytes = 20;
    localparam logic [39:0] cmd_fixed [2] = '{40'h40_0000_0000, 40'h48_0000_01AA};
    localparam logic [7:0] crc_fixed [2] = '{8'h95, 8'h87};    // known CMD0 and CMD8 CRC bytes

    typedef struct packed {
        logic rx;
        logic crc;
        logic [1:0] cmd;                                        // 0 data, 1 CMD0, 2 CMD8
        logic [7:0] scaler;
        logic [7:0] npush;
        logic [7:0] nbytes;
    } case_cfg_t;

    // rx, crc, cmd, scaler, bytes pushed, bytes in the count
    case_cfg_t case_cfg [n_cases] = '{
        '{1'b0, 1'b0, 2'd0, 8'd2, 8'd4, 8'd4},                  // plain transmit
        '{1'b0, 1'b0, 2'd0, 8'd3, 8'd2, 8'd5},                  // TX FIFO runs dry
        '{1'b0, 1'b1, 2'd1, 8'd2, 8'd5, 8'd5},                  // CMD0
        '{1'b0, 1'b1, 2'd2, 8'd1, 8'd5, 8'd5},                  // CMD8 at the fastest scaler
        '{1'b0, 1'b1, 2'd0, 8'd4, 8'd5, 8'd5},                  // random command
        '{1'b1, 1'b0, 2'd0, 8'd2, 8'd0, 8'd6},                  // receive
        '{1'b1, 1'b0, 2'd0, 8'd1, 8'd0, 8'd16},                 // receive into a full RX FIFO
        '{1'b0, 1'b0, 2'd0, 8'd2, 8'd17, 8'd17}                 // one push past a full TX FIFO
    };

    logic i_clk;
    logic i_nrst;
    sdspi_pkg::bus_req_t i_req;
    sdspi_pkg::bus_resp_t o_resp;
    logic o_cs;
    logic o_sclk;
    logic o_mosi;
    logic i_miso;
    logic [7:0] case_data [n_cases][max_bytes];
    logic [7:0] case_exp [n_cases][max_bytes];
    logic [7:0] mosi_bytes [max_bytes];                         // what the card saw
    int card_case;                                              // table row the card answers from
    int card_bits;
    logic sclk_prev;
    integer seed;
    int cycles;
    int cycle_limit;

    sdspi_top uut (
        .i_clk(i_clk), .i_nrst(i_nrst), .i_req(i_req), .o_resp(o_resp),
        .o_cs(o_cs), .o_sclk(o_sclk), .o_mosi(o_mosi), .i_miso(i_miso)
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = !i_clk;
    end

    always @(posedge i_clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles, a transfer never returned to idle", cycles);
            $display("Test FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s: got %h, expected %h", $time, name, got, exp);
            $display("Test FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // card answers MSB first and records MOSI on rising SCLK
    always @(negedge i_clk) begin
        if (!o_cs && o_sclk && !sclk_prev) begin
            mosi_bytes[card_bits / 8] = {mosi_bytes[card_bits / 8][6:0], o_mosi};
            if (case_cfg[card_case].rx) begin
                check_value("o_mosi", o_mosi, 1'b1);            // host idles high while reading
            end
            card_bits = card_bits + 1;
        end
        sclk_prev = o_sclk;
        if (!o_cs && !o_sclk) begin
            i_miso = case_data[card_case][card_bits / 8][7 - card_bits % 8];
        end
    end

    task automatic bus_access(input logic is_write, input logic [11:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        @(negedge i_clk);
        i_req = '{valid: 1'b1, write: is_write, addr: {20'h0, addr}, wdata: wdata};
        @(negedge i_clk);
        i_req = '0;
        while (!o_resp.valid) begin
            @(negedge i_clk);
        end
        rdata = o_resp.rdata;
    endtask

    // bit-serial CRC7 over x^7 + x^3 + 1
    function automatic logic [6:0] crc7_update(input logic [6:0] crc, input logic [7:0] data);
        logic [6:0] c;
        logic fb;
        c = crc;
        for (int i = 7; i >= 0; i--) begin
            fb = c[6] ^ data[i];
            c = {c[5:0], 1'b0} ^ {3'b000, fb, 2'b00, fb};
        end
        return c;
    endfunction

    task automatic build_table();
        logic [6:0] crc;
        int sent;
        for (int c = 0; c < n_cases; c++) begin
            crc = '0;
            sent = case_cfg[c].npush;
            if (sent > sdspi_pkg::fifo_depth) begin
                sent = sdspi_pkg::fifo_depth;                   // extra push is dropped
            end
            for (int b = 0; b < max_bytes; b++) begin
                case_data[c][b] = $random(seed);
                case_exp[c][b] = 8'hFF;                         // empty FIFO sends ones
            end
            if (case_cfg[c].cmd != 2'd0) begin
                for (int b = 0; b < 5; b++) begin
                    case_data[c][b] = cmd_fixed[case_cfg[c].cmd - 1][39 - 8 * b -: 8];
                end
            end else if (case_cfg[c].crc) begin
                case_data[c][0][7:6] = 2'b01;                   // start and direction bits
            end
            for (int b = 0; b < case_cfg[c].nbytes; b++) begin
                if (case_cfg[c].rx || b < sent) begin
                    case_exp[c][b] = case_data[c][b];
                end
                crc = crc7_update(crc, case_exp[c][b]);
            end
            if (case_cfg[c].crc) begin
                case_exp[c][case_cfg[c].nbytes] = (case_cfg[c].cmd == 2'd0) ?
                    {crc, 1'b1} : crc_fixed[case_cfg[c].cmd - 1];
                if (case_cfg[c].cmd != 2'd0) begin
                    check_value("model crc7", {crc, 1'b1}, crc_fixed[case_cfg[c].cmd - 1]);
                end
            end
            cycle_limit = cycle_limit + (case_cfg[c].nbytes + 2) * 16 * case_cfg[c].scaler;
        end
    endtask

    task automatic run_case(input int c);
        logic [31:0] rd;
        int total;
        total = case_cfg[c].nbytes + case_cfg[c].crc;
        card_case = c;
        card_bits = 0;
        bus_access(1'b1, sdspi_pkg::addr_scaler, case_cfg[c].scaler, rd);
        for (int b = 0; b < case_cfg[c].npush; b++) begin
            bus_access(1'b1, sdspi_pkg::addr_txdata, case_data[c][b], rd);
        end
        bus_access(1'b0, sdspi_pkg::addr_txdata, '0, rd);
        check_value("txdata.full", rd[31], case_cfg[c].npush >= sdspi_pkg::fifo_depth);
        bus_access(1'b1, sdspi_pkg::addr_ctrl,
                   {8'h00, case_cfg[c].nbytes, 7'h00, case_cfg[c].rx, case_cfg[c].crc, 7'h00}, rd);
        rd = '1;
        while (rd[6:4] != sdspi_pkg::idle || rd[31:16] != '0) begin
            bus_access(1'b0, sdspi_pkg::addr_ctrl, '0, rd);  // poll until the engine is done
        end
        check_value("status.rx_ena", rd[8], case_cfg[c].rx);
        check_value("status.generate_crc", rd[7], 1'b0);      // CRC request used up
        check_value("status.miso", rd[2], i_miso);
        check_value("o_cs", o_cs, 1'b1);
        check_value("sclk rises", card_bits, 8 * total);
        for (int b = 0; b < total; b++) begin
            if (case_cfg[c].rx) begin
                bus_access(1'b0, sdspi_pkg::addr_rxdata, '0, rd);
                check_value("rxdata", rd[7:0], case_exp[c][b]);
            end else begin
                check_value("mosi byte", mosi_bytes[b], case_exp[c][b]);
            end
        end
        bus_access(1'b0, sdspi_pkg::addr_rxdata, '0, rd);
        check_value("rxdata.empty", rd[31], 1'b1);
    endtask

    initial begin
        logic [31:0] rd;
        logic [31:0] val;
        seed = 32'hc839;
        i_nrst = 1'b0;
        i_req = '0;
        i_miso = 1'b1;
        card_case = 0;
        card_bits = 0;
        sclk_prev = 1'b0;
        cycles = 0;
        cycle_limit = 3000;                                     // margin for bus traffic
        build_table();
        repeat (8) @(negedge i_clk);
        i_nrst = 1'b1;
        check_value("o_cs", o_cs, 1'b1);
        check_value("o_sclk", o_sclk, 1'b0);
        check_value("o_mosi", o_mosi, 1'b1);
        check_value("o_resp.valid", o_resp.valid, 1'b0);
        bus_access(1'b0, sdspi_pkg::addr_scaler, '0, rd);
        check_value("scaler", rd, '0);
        bus_access(1'b0, sdspi_pkg::addr_rxdata, '0, rd);
        check_value("rxdata.empty", rd[31], 1'b1);
        repeat (4) begin
            val = $random(seed);
            bus_access(1'b1, sdspi_pkg::addr_scaler, val, rd);
            bus_access(1'b0, sdspi_pkg::addr_scaler, '0, rd);
            check_value("scaler", rd, {1'b0, val[30:0]});     // top bit is not stored
        end
        for (int c = 0; c < n_cases; c++) begin
            run_case(c);
        end
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire
